// ==== filelist.f ====
hw/fb_pkg.sv
hw/fb_regs.sv
hw/pulse_drive.sv
hw/xy_pi_clip.sv
hw/fb_top.sv
sim/fb_tb.sv

// ==== hw/fb_pkg.sv ====
package fb_pkg;

    // datapath widths
    typedef logic signed [17:0] sample_t;
    typedef logic signed [17:0] amp_t;
    // pulse width in clock cycles, 0 and 1 give no pulse
    typedef logic [6:0] width_t;
    typedef logic signed [15:0] gain_t;

    // gain products are scaled down by this shift
    localparam int GAIN_SHIFT = 8;
    localparam int INTEG_W = 24;
    // full gain times sample product
    localparam int PROD_W = 34;
    // product after the gain shift
    localparam int TERM_W = PROD_W - GAIN_SHIFT;

    typedef logic signed [INTEG_W-1:0] integ_t;
    typedef logic signed [TERM_W-1:0] term_t;

    // integrator saturation bounds
    localparam integ_t INTEG_MAX = {1'b0, {(INTEG_W-1){1'b1}}};
    localparam integ_t INTEG_MIN = {1'b1, {(INTEG_W-1){1'b0}}};

    typedef logic [7:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // register map, byte offsets
    localparam apb_addr_t REG_CTRL = 8'h00;
    localparam apb_addr_t REG_AMP_X = 8'h04;
    localparam apb_addr_t REG_AMP_Y = 8'h08;
    localparam apb_addr_t REG_WTH = 8'h0C;
    localparam apb_addr_t REG_KP = 8'h10;
    localparam apb_addr_t REG_KI = 8'h14;
    localparam apb_addr_t REG_CLIP = 8'h18;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic pready;
        logic pslverr;
    } apb_rsp_t;

    // software configuration, clip_limit is a positive magnitude
    typedef struct packed {
        logic enable;
        amp_t amp_x;
        amp_t amp_y;
        width_t wth;
        gain_t kp;
        gain_t ki;
        sample_t clip_limit;
    } fb_cfg_t;

endpackage

// ==== hw/fb_regs.sv ====
`timescale 1ns/1ps

module fb_regs (
    input  logic             clk,
    input  logic             rst,
    input  fb_pkg::apb_req_t apb_req,
    output fb_pkg::apb_rsp_t apb_rsp,
    output fb_pkg::fb_cfg_t  cfg
);

    fb_pkg::fb_cfg_t cfg_q;
    fb_pkg::apb_data_t rd_data;
    logic access;
    logic mapped;

    // second cycle of a transfer
    assign access = apb_req.psel && apb_req.penable;

    // offset decode and read mux
    always_comb begin
        mapped = 1'b1;
        rd_data = '0;
        case (apb_req.paddr)
            fb_pkg::REG_CTRL: rd_data = {31'b0, cfg_q.enable};
            // signed fields come back sign-extended
            fb_pkg::REG_AMP_X: rd_data = {{14{cfg_q.amp_x[17]}}, cfg_q.amp_x};
            fb_pkg::REG_AMP_Y: rd_data = {{14{cfg_q.amp_y[17]}}, cfg_q.amp_y};
            fb_pkg::REG_WTH: rd_data = {25'b0, cfg_q.wth};
            fb_pkg::REG_KP: rd_data = {{16{cfg_q.kp[15]}}, cfg_q.kp};
            fb_pkg::REG_KI: rd_data = {{16{cfg_q.ki[15]}}, cfg_q.ki};
            fb_pkg::REG_CLIP: rd_data = {{14{cfg_q.clip_limit[17]}}, cfg_q.clip_limit};
            default: mapped = 1'b0;
        endcase
    end

    // no wait states, the bank answers in the access cycle
    always_comb begin
        apb_rsp.pready = 1'b1;
        apb_rsp.prdata = (access && !apb_req.pwrite) ? rd_data : '0;
        apb_rsp.pslverr = access && !mapped;
    end

    // register write at the edge that ends the access cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q <= '0;
        end else if (access && apb_req.pwrite) begin
            case (apb_req.paddr)
                fb_pkg::REG_CTRL: cfg_q.enable <= apb_req.pwdata[0];
                fb_pkg::REG_AMP_X: cfg_q.amp_x <= apb_req.pwdata[17:0];
                fb_pkg::REG_AMP_Y: cfg_q.amp_y <= apb_req.pwdata[17:0];
                fb_pkg::REG_WTH: cfg_q.wth <= apb_req.pwdata[6:0];
                fb_pkg::REG_KP: cfg_q.kp <= apb_req.pwdata[15:0];
                fb_pkg::REG_KI: cfg_q.ki <= apb_req.pwdata[15:0];
                fb_pkg::REG_CLIP: cfg_q.clip_limit <= apb_req.pwdata[17:0];
                // unmapped offsets leave every field alone
                default: cfg_q <= cfg_q;
            endcase
        end
    end

    assign cfg = cfg_q;

    // master side protocol checks
    // penable only ever comes with psel
    penable_needs_psel: assert property (
        @(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel
    ) else $error("apb penable high without psel");

    // access phase lasts exactly one cycle since pready is tied high
    access_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        (apb_req.psel && apb_req.penable) |=> !apb_req.penable
    ) else $error("apb access phase held longer than one cycle");

endmodule

// ==== hw/fb_top.sv ====
`timescale 1ns/1ps

module fb_top (
    input  logic             clk,
    input  logic             rst,
    input  fb_pkg::apb_req_t apb_req,
    output fb_pkg::apb_rsp_t apb_rsp,
    input  fb_pkg::sample_t  err_xy,
    input  logic             iq,
    input  logic             bunch_arrival_trig,
    output fb_pkg::sample_t  drive_xy,
    output logic             drive_iq
);

    // software configuration from the register bank
    fb_pkg::fb_cfg_t cfg;
    // interleaved kick, one cycle behind iq
    fb_pkg::sample_t tri_out_xy;

    fb_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .cfg     (cfg)
    );

    // triggered triangle kick
    pulse_drive u_pulse (
        .clk                (clk),
        .rst                (rst),
        .iq                 (iq),
        .amp_x              (cfg.amp_x),
        .amp_y              (cfg.amp_y),
        .wth                (cfg.wth),
        .bunch_arrival_trig (bunch_arrival_trig),
        .tri_out_xy         (tri_out_xy)
    );

    // PI loop plus kick, clipped, 2 cycles from err_xy
    xy_pi_clip u_pi (
        .clk        (clk),
        .rst        (rst),
        .enable     (cfg.enable),
        .kp         (cfg.kp),
        .ki         (cfg.ki),
        .clip_limit (cfg.clip_limit),
        .err_xy     (err_xy),
        .iq         (iq),
        .tri_out_xy (tri_out_xy),
        .drive_xy   (drive_xy),
        .drive_iq   (drive_iq)
    );

endmodule

// ==== hw/pulse_drive.sv ====
`timescale 1ns/1ps

module pulse_drive (
    input  logic            clk,
    input  logic            rst,
    input  logic            iq,
    input  fb_pkg::amp_t    amp_x,
    input  fb_pkg::amp_t    amp_y,
    input  fb_pkg::width_t  wth,
    input  logic            bunch_arrival_trig,
    output fb_pkg::sample_t tri_out_xy
);

    fb_pkg::width_t cnt;
    logic active;
    // 1 while climbing towards the peak
    logic ramp_up;

    fb_pkg::width_t wth_m1;
    fb_pkg::width_t mid;
    fb_pkg::width_t div_w;
    fb_pkg::amp_t amp_sel;
    logic signed [7:0] step_k;
    logic signed [26:0] tri_prod;
    logic signed [26:0] tri_quot;
    logic signed [24:0] tri_scaled;
    fb_pkg::sample_t tri_round;

    assign wth_m1 = wth - 7'd1;
    // peak count, widths 0 and 1 collapse to a single zero sample
    assign mid = (wth > 7'd1) ? (wth_m1 >> 1) : '0;
    // keep the divider away from zero on degenerate widths
    assign div_w = (wth > 7'd1) ? wth_m1 : 7'd1;

    // interleaved stream, iq low is X
    assign amp_sel = iq ? amp_y : amp_x;

    // triangle counter
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            ramp_up <= 1'b0;
            cnt <= '0;
        end else if (bunch_arrival_trig && !active) begin
            // fresh pulse
            active <= 1'b1;
            ramp_up <= 1'b1;
            cnt <= '0;
        end else if (bunch_arrival_trig) begin
            // retrigger, climb again from wherever cnt is
            ramp_up <= 1'b1;
        end else if (active) begin
            if (ramp_up && (cnt < mid)) begin
                cnt <= cnt + 7'd1;
            end else begin
                // at or past the peak, head back down
                ramp_up <= 1'b0;
                if (cnt != '0) begin
                    cnt <= cnt - 7'd1;
                end else begin
                    active <= 1'b0;
                end
            end
        end
    end

    // scaled triangle value for the current count
    always_comb begin
        // cnt walks back down the same steps, so it sets the height on both sides
        step_k = {1'b0, cnt};
        tri_prod = (step_k * amp_sel) <<< 1;
        // signed divide truncates towards zero
        tri_quot = tri_prod / $signed({1'b0, div_w});
        tri_scaled = tri_quot[24:0];
        // drop 8 fraction bits, round on bit 7
        tri_round = fb_pkg::sample_t'(tri_scaled >>> 8) + fb_pkg::sample_t'(tri_scaled[7]);
    end

    // registered output, one cycle after cnt and iq
    always_ff @(posedge clk) begin
        if (rst) begin
            tri_out_xy <= '0;
        end else if (active && (wth > 7'd1)) begin
            tri_out_xy <= tri_round;
        end else begin
            tri_out_xy <= '0;
        end
    end

    // counter stays below the peak for the whole pulse
    cnt_within_mid: assert property (
        @(posedge clk) disable iff (rst)
        active |-> (cnt <= mid)
    ) else $error("pulse counter ran past the triangle midpoint");

endmodule

// ==== hw/xy_pi_clip.sv ====
`timescale 1ns/1ps

module xy_pi_clip (
    input  logic            clk,
    input  logic            rst,
    input  logic            enable,
    input  fb_pkg::gain_t   kp,
    input  fb_pkg::gain_t   ki,
    input  fb_pkg::sample_t clip_limit,
    input  fb_pkg::sample_t err_xy,
    input  logic            iq,
    input  fb_pkg::sample_t tri_out_xy,
    output fb_pkg::sample_t drive_xy,
    output logic            drive_iq
);

    // one integrator per plane, index 0 is X
    fb_pkg::integ_t integ [2];

    logic signed [fb_pkg::PROD_W-1:0] p_prod;
    logic signed [fb_pkg::PROD_W-1:0] i_prod;
    fb_pkg::term_t p_term;
    fb_pkg::term_t i_term;
    fb_pkg::integ_t integ_cur;
    // one guard bit for the integrator add
    logic signed [fb_pkg::TERM_W:0] integ_sum;
    fb_pkg::integ_t integ_next;

    // stage 1 pipeline registers
    logic s1_iq;
    fb_pkg::term_t p_s1;
    fb_pkg::integ_t i_s1;

    logic signed [fb_pkg::TERM_W+1:0] pi_sum;
    logic signed [fb_pkg::TERM_W+1:0] clip_neg;
    fb_pkg::sample_t drive_next;

    // stage 1 arithmetic
    always_comb begin
        p_prod = kp * err_xy;
        i_prod = ki * err_xy;
        // arithmetic shift keeps the sign of the error
        p_term = fb_pkg::term_t'(p_prod >>> fb_pkg::GAIN_SHIFT);
        i_term = fb_pkg::term_t'(i_prod >>> fb_pkg::GAIN_SHIFT);
        integ_cur = integ[iq];
        integ_sum = integ_cur + i_term;
        // saturate the integrator instead of wrapping
        if (integ_sum > fb_pkg::INTEG_MAX) begin
            integ_next = fb_pkg::INTEG_MAX;
        end else if (integ_sum < fb_pkg::INTEG_MIN) begin
            integ_next = fb_pkg::INTEG_MIN;
        end else begin
            integ_next = fb_pkg::integ_t'(integ_sum);
        end
    end

    // integrators, cleared and held while the loop is off
    always_ff @(posedge clk) begin
        if (rst) begin
            integ[0] <= '0;
            integ[1] <= '0;
        end else if (!enable) begin
            integ[0] <= '0;
            integ[1] <= '0;
        end else begin
            integ[iq] <= integ_next;
        end
    end

    // stage 1 registers, plane tag rides along with the data
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_iq <= 1'b0;
        end else begin
            s1_iq <= iq;
        end
    end

    always_ff @(posedge clk) begin
        p_s1 <= p_term;
        // post-update integrator value of this plane
        i_s1 <= enable ? integ_next : '0;
    end

    // stage 2, add the pulse and clip
    // tri_out_xy here belongs to the sample now in stage 1
    always_comb begin
        pi_sum = p_s1 + i_s1 + tri_out_xy;
        clip_neg = 0 - clip_limit;
        if (pi_sum > clip_limit) begin
            drive_next = clip_limit;
        end else if (pi_sum < clip_neg) begin
            drive_next = fb_pkg::sample_t'(clip_neg);
        end else begin
            drive_next = fb_pkg::sample_t'(pi_sum);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            drive_xy <= '0;
            drive_iq <= 1'b0;
        end else begin
            drive_iq <= s1_iq;
            drive_xy <= enable ? drive_next : '0;
        end
    end

    // output bounded by the limit in force when it was registered
    drive_in_clip: assert property (
        @(posedge clk) disable iff (rst)
        (drive_xy <= $past(clip_limit)) && (drive_xy >= -$past(clip_limit))
    ) else $error("drive output outside the clip limit");

endmodule

// ==== sim/fb_tb.sv ====
`timescale 1ns/1ps

module fb_tb;

    localparam longint INTEG_HI = 2 ** (fb_pkg::INTEG_W - 1) - 1;
    localparam longint BIG_CLIP = 131071;

    logic clk;
    logic rst;
    logic iq;
    logic bunch_arrival_trig;
    fb_pkg::apb_req_t apb_req;
    fb_pkg::apb_rsp_t apb_rsp;
    fb_pkg::sample_t err_xy;
    fb_pkg::sample_t drive_xy;
    logic drive_iq;

    string test_name;
    logic [31:0] lfsr;
    logic rand_err;
    logic [31:0] exp_rdata;
    logic exp_err;

    // reference model state, all updated at the rising edge
    fb_pkg::fb_cfg_t shadow;
    bit act_m;
    bit up_m;
    int cnt_m;
    int mid_m;
    longint tri_m;
    longint integ_m [2];
    longint p_m;
    longint i_m;
    longint nxt_m;
    longint p1_m;
    longint i1_m;
    bit iq1_m;
    longint exp_drive;
    bit exp_iq;

    fb_pkg::apb_addr_t reg_list [7] = '{fb_pkg::REG_CTRL, fb_pkg::REG_AMP_X,
        fb_pkg::REG_AMP_Y, fb_pkg::REG_WTH, fb_pkg::REG_KP, fb_pkg::REG_KI, fb_pkg::REG_CLIP};

    // odd, even and degenerate pulse widths
    int pulse_widths [3] = '{9, 8, 1};

    fb_top uut (
        .clk                (clk),
        .rst                (rst),
        .apb_req            (apb_req),
        .apb_rsp            (apb_rsp),
        .err_xy             (err_xy),
        .iq                 (iq),
        .bunch_arrival_trig (bunch_arrival_trig),
        .drive_xy           (drive_xy),
        .drive_iq           (drive_iq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic longint clamp(longint v, longint lo, longint hi);
        return (v > hi) ? hi : ((v < lo) ? lo : v);
    endfunction

    // triangle sample: 2*cnt*amp/(wth-1), drop 8 bits, round on bit 7
    function automatic longint tri_value(int cnt, longint amp, int w);
        longint q;
        if (w <= 1) return 0;
        q = (2 * cnt * amp) / (w - 1);
        return (q >>> 8) + ((q >> 7) & 1);
    endfunction

    function automatic bit is_mapped(fb_pkg::apb_addr_t a);
        foreach (reg_list[k]) if (reg_list[k] == a) return 1'b1;
        return 1'b0;
    endfunction

    // stored value as software sees it, signed fields sign-extended
    function automatic logic [31:0] readback(fb_pkg::apb_addr_t a);
        case (a)
            fb_pkg::REG_CTRL: return {31'b0, shadow.enable};
            fb_pkg::REG_AMP_X: return 32'(shadow.amp_x);
            fb_pkg::REG_AMP_Y: return 32'(shadow.amp_y);
            fb_pkg::REG_WTH: return {25'b0, shadow.wth};
            fb_pkg::REG_KP: return 32'(shadow.kp);
            fb_pkg::REG_KI: return 32'(shadow.ki);
            fb_pkg::REG_CLIP: return 32'(shadow.clip_limit);
            default: return '0;
        endcase
    endfunction

    // cycle model of the register bank, pulse generator and PI/clip pipeline
    always @(posedge clk) begin
        if (rst) begin
            shadow = '0;
            act_m = 0;
            up_m = 0;
            cnt_m = 0;
            tri_m = 0;
            integ_m[0] = 0;
            integ_m[1] = 0;
            p1_m = 0;
            i1_m = 0;
            iq1_m = 0;
            exp_drive = 0;
            exp_iq = 0;
        end else begin
            // stage 2 takes stage 1 plus the pulse registered alongside it
            exp_iq = iq1_m;
            exp_drive = shadow.enable ? clamp(p1_m + i1_m + tri_m,
                -longint'(shadow.clip_limit), longint'(shadow.clip_limit)) : 0;
            p_m = (longint'(shadow.kp) * longint'(err_xy)) >>> fb_pkg::GAIN_SHIFT;
            i_m = (longint'(shadow.ki) * longint'(err_xy)) >>> fb_pkg::GAIN_SHIFT;
            nxt_m = clamp(integ_m[iq] + i_m, -INTEG_HI - 1, INTEG_HI);
            if (shadow.enable) begin
                integ_m[iq] = nxt_m;
                i1_m = nxt_m;
            end else begin
                integ_m[0] = 0;
                integ_m[1] = 0;
                i1_m = 0;
            end
            p1_m = p_m;
            iq1_m = iq;
            // pulse register sees the count from before this edge
            tri_m = act_m ? tri_value(cnt_m, iq ? shadow.amp_y : shadow.amp_x, shadow.wth) : 0;
            mid_m = (shadow.wth > 1) ? (shadow.wth - 1) / 2 : 0;
            if (bunch_arrival_trig && !act_m) begin
                act_m = 1;
                up_m = 1;
                cnt_m = 0;
            end else if (bunch_arrival_trig) begin
                up_m = 1;
            end else if (act_m) begin
                if (up_m && cnt_m < mid_m) begin
                    cnt_m++;
                end else begin
                    up_m = 0;
                    if (cnt_m != 0) cnt_m--;
                    else act_m = 0;
                end
            end
            // writes land at the edge ending the access
            if (apb_req.psel && apb_req.penable && apb_req.pwrite) begin
                case (apb_req.paddr)
                    fb_pkg::REG_CTRL: shadow.enable = apb_req.pwdata[0];
                    fb_pkg::REG_AMP_X: shadow.amp_x = apb_req.pwdata[17:0];
                    fb_pkg::REG_AMP_Y: shadow.amp_y = apb_req.pwdata[17:0];
                    fb_pkg::REG_WTH: shadow.wth = apb_req.pwdata[6:0];
                    fb_pkg::REG_KP: shadow.kp = apb_req.pwdata[15:0];
                    fb_pkg::REG_KI: shadow.ki = apb_req.pwdata[15:0];
                    fb_pkg::REG_CLIP: shadow.clip_limit = apb_req.pwdata[17:0];
                    default: ;
                endcase
            end
        end
    end

    drive_matches_model: assert property (@(posedge clk) disable iff (rst)
        (drive_xy == exp_drive) && (drive_iq == exp_iq))
    else begin
        $display("** Error [%s] drive_xy/iq expected %0d/%0b actual %0d/%0b", test_name,
            $sampled(exp_drive), $sampled(exp_iq), $sampled(drive_xy), $sampled(drive_iq));
        stop_on_error();
    end

    // read data and slave error only in the access cycle
    apb_matches_model: assert property (@(posedge clk) disable iff (rst)
        (apb_req.psel && apb_req.penable) ? ((apb_rsp.pslverr == exp_err)
        && (apb_req.pwrite || apb_rsp.prdata == exp_rdata)) : !apb_rsp.pslverr)
    else begin
        $display("** Error [%s] offset %h expected prdata %h pslverr %0b actual %h %0b",
            test_name, $sampled(apb_req.paddr), $sampled(exp_rdata), $sampled(exp_err),
            $sampled(apb_rsp.prdata), $sampled(apb_rsp.pslverr));
        stop_on_error();
    end

    task automatic apb_access(input logic wr, input fb_pkg::apb_addr_t a, input logic [31:0] d);
        int waited;
        @(negedge clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: a, pwdata: d};
        @(negedge clk);
        apb_req.penable = 1'b1;
        exp_err = !is_mapped(a);
        exp_rdata = (wr || !is_mapped(a)) ? '0 : readback(a);
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!apb_rsp.pready && waited < 16);
        if (!apb_rsp.pready) begin
            $display("APB access to offset %h got no pready within 16 cycles", a);
            stop_on_error();
        end
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic run_cycles(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic fire_trigger();
        @(negedge clk);
        bunch_arrival_trig = 1'b1;
        @(negedge clk);
        bunch_arrival_trig = 1'b0;
    endtask

    task automatic wait_pulse_idle();
        int n;
        n = 0;
        while (act_m && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (act_m) begin
            $display("pulse still active after 200 cycles");
            stop_on_error();
        end
        // let the pulse register and both pipeline stages drain
        run_cycles(4);
    endtask

    // interleaved stream, plane flips every cycle
    initial begin
        iq = 1'b0;
        err_xy = '0;
        forever begin
            @(negedge clk);
            iq = ~iq;
            err_xy = rand_err ? fb_pkg::sample_t'(rand_bits(18)) : '0;
        end
    end

    initial begin
        rst = 1'b1;
        bunch_arrival_trig = 1'b0;
        apb_req = '0;
        rand_err = 1'b0;
        lfsr = 32'h488e;
        exp_rdata = '0;
        exp_err = 1'b0;
        test_name = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "register access";
        apb_access(1, fb_pkg::REG_AMP_X, 32'h0003_ffff);
        apb_access(1, fb_pkg::REG_AMP_Y, 32'h0001_2345);
        apb_access(1, fb_pkg::REG_WTH, 32'hffff_ff85);
        apb_access(1, fb_pkg::REG_KP, 32'h0000_8001);
        apb_access(1, fb_pkg::REG_KI, 32'h1234_7fff);
        apb_access(1, fb_pkg::REG_CLIP, 32'hfffc_1234);
        apb_access(1, fb_pkg::REG_CTRL, 32'h0000_0003);
        foreach (reg_list[k]) apb_access(0, reg_list[k], '0);
        // unmapped offsets, must leave the bank untouched
        apb_access(1, 8'h1C, 32'hdead_beef);
        apb_access(1, 8'h02, 32'h0000_0000);
        apb_access(0, 8'h40, '0);
        foreach (reg_list[k]) apb_access(0, reg_list[k], '0);

        test_name = "pulse shape";
        apb_access(1, fb_pkg::REG_KP, 32'h0);
        apb_access(1, fb_pkg::REG_KI, 32'h0);
        apb_access(1, fb_pkg::REG_CLIP, 32'(BIG_CLIP));
        apb_access(1, fb_pkg::REG_AMP_X, 32'd30000);
        apb_access(1, fb_pkg::REG_AMP_Y, -32'sd45000);
        foreach (pulse_widths[w]) begin
            apb_access(1, fb_pkg::REG_WTH, 32'(pulse_widths[w]));
            fire_trigger();
            wait_pulse_idle();
        end

        test_name = "retrigger";
        apb_access(1, fb_pkg::REG_WTH, 32'd21);
        fire_trigger();
        // land the second trigger somewhere in the falling half
        run_cycles(12 + int'(rand_bits(3)));
        fire_trigger();
        wait_pulse_idle();

        test_name = "pi action";
        apb_access(1, fb_pkg::REG_KP, 32'd40);
        apb_access(1, fb_pkg::REG_KI, 32'd3);
        rand_err = 1'b1;
        run_cycles(200);

        test_name = "clip and disable";
        apb_access(1, fb_pkg::REG_KP, 32'd300);
        apb_access(1, fb_pkg::REG_CLIP, 32'd600);
        run_cycles(60);
        apb_access(1, fb_pkg::REG_CTRL, 32'h0);
        // open the limit again so the restarted integrators show on the output
        apb_access(1, fb_pkg::REG_KP, 32'd40);
        apb_access(1, fb_pkg::REG_CLIP, 32'(BIG_CLIP));
        run_cycles(10);
        apb_access(1, fb_pkg::REG_CTRL, 32'h1);
        run_cycles(40);
        rand_err = 1'b0;
        run_cycles(4);

        $display("Verification passed");
        $finish;
    end

endmodule
